/* design/hins_pkg.sv */
package hins_pkg;

    // ========================================================================
    // widths
    // ========================================================================
    localparam int DATA_W = 32;                              // parameter word
    localparam int ADDR_W = 4;                               // register address
    localparam int DAC_W  = 16;                              // parallel DAC code

    // ========================================================================
    // constants
    // ========================================================================
    localparam logic [DAC_W-1:0] DAC_MID = 16'h8000;         // midscale, 32768
    localparam int TIMER_DIV = 100;                          // clocks per timer tick

    // register reset values, formerly tied off at the fog core
    localparam logic [DATA_W-1:0] FREQ_CNT_DEF = 32'd1000;   // half period, cycles
    localparam logic [DATA_W-1:0] AMP_H_DEF    = 32'd5000;   // high half above mid
    localparam logic [DATA_W-1:0] AMP_L_DEF    = 32'd5000;   // low half below mid
    localparam logic [DATA_W-1:0] SYNC_CNT_DEF = 32'd0;      // 0 keeps sync off

    // ========================================================================
    // register map, one 32-bit word per address
    // ========================================================================
    typedef enum logic [ADDR_W-1:0] {
        REG_FREQ_CNT   = 4'd0,  // rw, modulation half period
        REG_AMP_H      = 4'd1,  // rw, high amplitude
        REG_AMP_L      = 4'd2,  // rw, low amplitude
        REG_SYNC_COUNT = 4'd3,  // rw, sync period
        REG_TIMER_RST  = 4'd4,  // rw, bit 0 clears timer
        REG_DAC_RST    = 4'd5,  // rw, bit 0 to dac reset pin
        REG_TIMER      = 4'd6   // ro, live timer value
    } reg_addr_e;

    // ========================================================================
    // modulation half
    // ========================================================================
    typedef enum logic {
        MOD_HIGH = 1'b0,        // mid + amp_h
        MOD_LOW  = 1'b1         // mid - amp_l
    } mod_state_e;

endpackage

/* design/hins_rst_sync.sv */
`timescale 1ns/1ps

module hins_rst_sync (
    input  logic pll_clk_cpu_int,
    input  logic RST_EXT_N,
    input  logic i_pll_locked,   // async to cpu clock
    output logic o_rst_sync_n    // active-low internal reset
);

    logic r_lock_meta;           // first stage may go metastable
    logic r_lock_sync;           // second stage

    always_ff @(posedge pll_clk_cpu_int or negedge RST_EXT_N) begin
        if (!RST_EXT_N) begin
            r_lock_meta <= 1'b0;
            r_lock_sync <= 1'b0;
        end else begin
            r_lock_meta <= i_pll_locked;
            r_lock_sync <= r_lock_meta;
        end
    end

    assign o_rst_sync_n = r_lock_sync; // deasserts two edges after lock

    // release only while lock is still up
    a_release_after_lock: assert property (@(posedge pll_clk_cpu_int) disable iff (!RST_EXT_N)
        $rose(o_rst_sync_n) |-> i_pll_locked);

endmodule

/* design/hins_reg_bank.sv */
`timescale 1ns/1ps

module hins_reg_bank (
    input  logic                          pll_clk_cpu_int,
    input  logic                          i_rst_n,
    input  logic                          i_reg_wr,        // one-cycle write strobe
    input  hins_pkg::reg_addr_e           i_reg_waddr,
    input  logic [hins_pkg::DATA_W-1:0]   i_reg_wdata,
    input  hins_pkg::reg_addr_e           i_reg_raddr,
    input  logic [hins_pkg::DATA_W-1:0]   i_timer_value,   // live, from timer
    output logic [hins_pkg::DATA_W-1:0]   o_reg_rdata,
    output logic [hins_pkg::DATA_W-1:0]   o_freq_cnt,
    output logic [hins_pkg::DATA_W-1:0]   o_amp_h,
    output logic [hins_pkg::DATA_W-1:0]   o_amp_l,
    output logic [hins_pkg::DATA_W-1:0]   o_sync_count,
    output logic                          o_timer_clr,
    output logic                          o_dac_rst
);

    logic [hins_pkg::DATA_W-1:0] rd_mux;   // readback select, pre-register

    // ========================================================================
    // write side
    // ========================================================================
    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_freq_cnt   <= hins_pkg::FREQ_CNT_DEF;
            o_amp_h      <= hins_pkg::AMP_H_DEF;
            o_amp_l      <= hins_pkg::AMP_L_DEF;
            o_sync_count <= hins_pkg::SYNC_CNT_DEF;
            o_timer_clr  <= 1'b0;
            o_dac_rst    <= 1'b0;                    // dac out of reset
        end else if (i_reg_wr) begin
            case (i_reg_waddr)
                hins_pkg::REG_FREQ_CNT:   o_freq_cnt   <= i_reg_wdata;
                hins_pkg::REG_AMP_H:      o_amp_h      <= i_reg_wdata;
                hins_pkg::REG_AMP_L:      o_amp_l      <= i_reg_wdata;
                hins_pkg::REG_SYNC_COUNT: o_sync_count <= i_reg_wdata;
                hins_pkg::REG_TIMER_RST:  o_timer_clr  <= i_reg_wdata[0];
                hins_pkg::REG_DAC_RST:    o_dac_rst    <= i_reg_wdata[0];
                default: ;                               // timer ro, unmapped dropped
            endcase
        end
    end

    // ========================================================================
    // read side
    // ========================================================================
    always_comb begin
        case (i_reg_raddr)
            hins_pkg::REG_FREQ_CNT:   rd_mux = o_freq_cnt;
            hins_pkg::REG_AMP_H:      rd_mux = o_amp_h;
            hins_pkg::REG_AMP_L:      rd_mux = o_amp_l;
            hins_pkg::REG_SYNC_COUNT: rd_mux = o_sync_count;
            hins_pkg::REG_TIMER_RST:  rd_mux = {{(hins_pkg::DATA_W-1){1'b0}}, o_timer_clr};
            hins_pkg::REG_DAC_RST:    rd_mux = {{(hins_pkg::DATA_W-1){1'b0}}, o_dac_rst};
            hins_pkg::REG_TIMER:      rd_mux = i_timer_value;
            default:                  rd_mux = '0;       // unmapped reads zero
        endcase
    end

    // one clock of read latency
    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_rdata <= '0;
        end else begin
            o_reg_rdata <= rd_mux;
        end
    end

    // a floating strobe from the cpu side would corrupt parameters silently
    a_wr_known: assert property (@(posedge pll_clk_cpu_int) disable iff (!i_rst_n)
        !$isunknown(i_reg_wr));

endmodule

/* design/hins_sync_gen.sv */
`timescale 1ns/1ps

module hins_sync_gen (
    input  logic                        pll_clk_cpu_int,
    input  logic                        i_rst_n,
    input  logic [hins_pkg::DATA_W-1:0] i_sync_count,   // period, <2 disables
    output logic                        o_sync          // one-cycle pulse
);

    logic [hins_pkg::DATA_W-1:0] period_q;   // last seen period
    logic [hins_pkg::DATA_W-1:0] cnt;        // cycles to next pulse

    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            period_q <= hins_pkg::SYNC_CNT_DEF;
            cnt      <= '0;
            o_sync   <= 1'b0;
        end else if (i_sync_count != period_q) begin
            period_q <= i_sync_count;            // new period, restart count
            cnt      <= i_sync_count - 1'b1;
            o_sync   <= 1'b0;
        end else if (period_q < 2) begin
            cnt      <= '0;                      // 0 or 1, held off
            o_sync   <= 1'b0;
        end else if (cnt == '0) begin
            cnt      <= period_q - 1'b1;         // reload and fire
            o_sync   <= 1'b1;
        end else begin
            cnt      <= cnt - 1'b1;
            o_sync   <= 1'b0;
        end
    end

    // pulse never stretches past one clock
    a_sync_one_wide: assert property (@(posedge pll_clk_cpu_int) disable iff (!i_rst_n)
        o_sync |=> !o_sync);

endmodule

/* design/hins_timer.sv */
`timescale 1ns/1ps

module hins_timer (
    input  logic                        pll_clk_cpu_int,
    input  logic                        i_rst_n,
    input  logic                        i_timer_clr,   // level, holds at zero
    output logic [hins_pkg::DATA_W-1:0] o_timer
);

    logic [hins_pkg::DATA_W-1:0] presc;   // clock divider
    logic                        tick;    // one cycle per TIMER_DIV clocks

    assign tick = (presc == hins_pkg::DATA_W'(hins_pkg::TIMER_DIV - 1));

    // ========================================================================
    // prescaler and counter
    // ========================================================================
    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            presc   <= '0;
            o_timer <= '0;
        end else if (i_timer_clr) begin
            presc   <= '0;                      // clear both stages
            o_timer <= '0;
        end else if (tick) begin
            presc   <= '0;                      // wrap divider
            o_timer <= o_timer + 1'b1;          // free-running, wraps at 2^32
        end else begin
            presc   <= presc + 1'b1;
        end
    end

endmodule

/* design/hins_mod_gen.sv */
`timescale 1ns/1ps

module hins_mod_gen (
    input  logic                        pll_clk_cpu_int,
    input  logic                        i_rst_n,
    input  logic [hins_pkg::DATA_W-1:0] i_freq_cnt,   // half length where 0 acts as 1
    input  logic [hins_pkg::DATA_W-1:0] i_amp_h,
    input  logic [hins_pkg::DATA_W-1:0] i_amp_l,
    output logic [hins_pkg::DAC_W-1:0]  o_dac_data
);

    hins_pkg::mod_state_e        state;       // current half
    hins_pkg::mod_state_e        next_state;  // half after boundary
    logic [hins_pkg::DATA_W-1:0] half_cnt;    // cycles left in half
    logic [hins_pkg::DATA_W-1:0] code;        // untruncated dac code
    logic                        boundary;

    assign boundary = (half_cnt == '0);

    always_comb begin
        next_state = (state == hins_pkg::MOD_HIGH) ? hins_pkg::MOD_LOW : hins_pkg::MOD_HIGH;
        if (next_state == hins_pkg::MOD_HIGH) begin
            code = hins_pkg::DATA_W'(hins_pkg::DAC_MID) + i_amp_h;   // above mid
        end else begin
            code = hins_pkg::DATA_W'(hins_pkg::DAC_MID) - i_amp_l;   // below mid
        end
    end

    // ========================================================================
    // half-period FSM
    // ========================================================================
    // reset parks in the low half with the counter expired so the first
    // clock after reset is a boundary into the high half
    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= hins_pkg::MOD_LOW;
            half_cnt   <= '0;
            o_dac_data <= hins_pkg::DAC_MID;              // midscale in reset
        end else if (boundary) begin
            state      <= next_state;
            half_cnt   <= (i_freq_cnt == '0) ? '0 : i_freq_cnt - 1'b1;  // params latch here
            o_dac_data <= code[hins_pkg::DAC_W-1:0];      // wraps to 16 bits
        end else begin
            half_cnt   <= half_cnt - 1'b1;
        end
    end

    // state only ever holds one of the two halves
    a_state_legal: assert property (@(posedge pll_clk_cpu_int) disable iff (!i_rst_n)
        state inside {hins_pkg::MOD_HIGH, hins_pkg::MOD_LOW});

endmodule

/* design/hins_top.sv */
`timescale 1ns/1ps

module hins_top (
    input  logic                        pll_clk_cpu_int,
    input  logic                        RST_EXT_N,
    input  logic                        i_pll_locked,
    input  logic                        i_reg_wr,       // write strobe
    input  logic [hins_pkg::ADDR_W-1:0] i_reg_waddr,
    input  logic [hins_pkg::DATA_W-1:0] i_reg_wdata,
    input  logic [hins_pkg::ADDR_W-1:0] i_reg_raddr,
    output logic [hins_pkg::DATA_W-1:0] o_reg_rdata,    // one clock after raddr
    output logic                        o_sync,
    output logic [hins_pkg::DAC_W-1:0]  o_dac_data,
    output logic                        o_dac_rst
);

    logic                        rst_sync_n;    // internal reset, follows lock
    hins_pkg::reg_addr_e         waddr_e;       // addresses as map enum
    hins_pkg::reg_addr_e         raddr_e;
    logic [hins_pkg::DATA_W-1:0] freq_cnt;
    logic [hins_pkg::DATA_W-1:0] amp_h;
    logic [hins_pkg::DATA_W-1:0] amp_l;
    logic [hins_pkg::DATA_W-1:0] sync_count;
    logic [hins_pkg::DATA_W-1:0] timer_value;
    logic                        timer_clr;

    assign waddr_e = hins_pkg::reg_addr_e'(i_reg_waddr);   // unmapped values kept
    assign raddr_e = hins_pkg::reg_addr_e'(i_reg_raddr);

    // ========================================================================
    // reset and parameter window
    // ========================================================================
    hins_rst_sync u_rst_sync (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_pll_locked    (i_pll_locked),
        .o_rst_sync_n    (rst_sync_n)
    );

    hins_reg_bank u_reg_bank (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (rst_sync_n),
        .i_reg_wr        (i_reg_wr),
        .i_reg_waddr     (waddr_e),
        .i_reg_wdata     (i_reg_wdata),
        .i_reg_raddr     (raddr_e),
        .i_timer_value   (timer_value),   // readback only
        .o_reg_rdata     (o_reg_rdata),
        .o_freq_cnt      (freq_cnt),
        .o_amp_h         (amp_h),
        .o_amp_l         (amp_l),
        .o_sync_count    (sync_count),
        .o_timer_clr     (timer_clr),
        .o_dac_rst       (o_dac_rst)      // straight to pin
    );

    // ========================================================================
    // sync, timer, modulation
    // ========================================================================
    hins_sync_gen u_sync_gen (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (rst_sync_n),
        .i_sync_count    (sync_count),
        .o_sync          (o_sync)
    );

    hins_timer u_timer (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (rst_sync_n),
        .i_timer_clr     (timer_clr),
        .o_timer         (timer_value)
    );

    hins_mod_gen u_mod_gen (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (rst_sync_n),
        .i_freq_cnt      (freq_cnt),
        .i_amp_h         (amp_h),
        .i_amp_l         (amp_l),
        .o_dac_data      (o_dac_data)     // open loop, no ramp
    );

endmodule

/* dv/hins_checker.sv */
`timescale 1ns/1ps

module hins_checker (
    input  logic                        pll_clk_cpu_int,
    input  logic                        i_reg_wr,        // dut inputs, watched
    input  logic [hins_pkg::ADDR_W-1:0] i_reg_raddr,
    input  logic [hins_pkg::DATA_W-1:0] i_reg_rdata,     // dut outputs, watched
    input  logic                        i_sync,
    input  logic [hins_pkg::DAC_W-1:0]  i_dac_data,
    input  logic                        i_dac_rst,
    input  logic [3:0]                  i_chk_req,       // rdata, sync, dac_rst, dac_data
    input  logic [hins_pkg::DATA_W-1:0] i_exp,
    input  logic [hins_pkg::DATA_W-1:0] i_tol,           // allowed distance from i_exp
    input  logic                        i_sync_mon,
    input  logic [hins_pkg::DATA_W-1:0] i_sync_period,
    input  logic                        i_dac_mon,
    input  logic [hins_pkg::DAC_W-1:0]  i_dac_hi,
    input  logic [hins_pkg::DAC_W-1:0]  i_dac_lo,
    input  logic [hins_pkg::DATA_W-1:0] i_dac_half,      // expected run length
    input  logic                        i_test_end,
    input  int                          i_test_num,
    input  logic                        i_all_done,
    output int                          o_fail_cnt
);

    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          test_fail = 0;    // errors in current test
    int          writes = 0;
    int          pulses = 0;
    int          runs = 0;         // complete halves seen
    logic [31:0] gap_cnt = '0;     // 0 until first pulse
    logic [31:0] run_len = '0;
    logic [15:0] dac_q = '0;
    logic        sync_q = 1'b0;
    logic        sync_mon_q = 1'b0;
    logic        dac_mon_q = 1'b0;
    logic        dac_started = 1'b0;
    logic        run_valid = 1'b0;   // current run began at a code change

    assign o_fail_cnt = fail_cnt;

    function automatic string test_name(input int num);
        case (num)
            1: return "reset state";
            2: return "register write and readback";
            3: return "sync period";
            4: return "timer";
            5: return "modulation waveform";
            6: return "loss of lock";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act, input logic [31:0] tol);
        logic [31:0] diff;
        diff = (act > exp) ? act - exp : exp - act;
        if (diff <= tol) begin
            pass_cnt++;
        end else begin
            $display("[FAIL] %s exp 0x%08h act 0x%08h", name, exp, act);
            fail_cnt++;
            test_fail++;
        end
    endtask

    task automatic log_error(input string msg);
        $display("%s", msg);
        fail_cnt++;
        test_fail++;
    endtask

    // ========================================================================
    // point checks, sampled at the rising edge before outputs update
    // ========================================================================
    always @(posedge pll_clk_cpu_int) begin
        if (i_reg_wr) writes++;
        if (i_chk_req[0]) compare_value($sformatf("o_reg_rdata[0x%h]", i_reg_raddr),
                                        i_exp, i_reg_rdata, i_tol);
        if (i_chk_req[1]) compare_value("o_sync", i_exp, {31'd0, i_sync}, '0);
        if (i_chk_req[2]) compare_value("o_dac_rst", i_exp, {31'd0, i_dac_rst}, '0);
        if (i_chk_req[3]) compare_value("o_dac_data", i_exp, {16'd0, i_dac_data}, '0);

        // sync pulse spacing and width
        if (i_sync_mon) begin
            if (i_sync && sync_q) log_error("o_sync stayed high for more than one cycle");
            if (i_sync) begin
                pulses++;
                if (i_sync_period < 2) begin
                    log_error("o_sync pulsed while its period disables it");
                end else if (gap_cnt != '0) begin
                    compare_value("o_sync gap", i_sync_period, gap_cnt, '0);
                end
                gap_cnt = 1;
            end else if (gap_cnt != '0) begin
                gap_cnt = gap_cnt + 1;
            end
        end else if (sync_mon_q) begin       // window closed
            if (i_sync_period >= 2 && pulses < 2) log_error("too few sync pulses seen");
            else if (i_sync_period < 2 && pulses == 0) pass_cnt++;
            gap_cnt = '0;
            pulses = 0;
        end

        // dac codes and half lengths
        if (i_dac_mon) begin
            if (i_dac_data != i_dac_hi && i_dac_data != i_dac_lo) begin
                $display("[FAIL] o_dac_data exp 0x%04h or 0x%04h act 0x%04h",
                         i_dac_hi, i_dac_lo, i_dac_data);
                fail_cnt++;
                test_fail++;
            end else if (dac_started && i_dac_data == dac_q) begin
                run_len = run_len + 1;
            end else begin
                if (run_valid) begin         // first run is partial, skipped
                    compare_value("o_dac_data run length", i_dac_half, run_len, '0);
                    runs++;
                end
                run_valid = dac_started;
                dac_started = 1'b1;
                run_len = 1;
            end
            dac_q = i_dac_data;
        end else if (dac_mon_q) begin
            if (runs < 2) log_error("too few complete o_dac_data halves seen");
            dac_started = 1'b0;
            run_valid = 1'b0;
            runs = 0;
        end

        sync_q = i_sync;
        sync_mon_q = i_sync_mon;
        dac_mon_q = i_dac_mon;

        if (i_test_end) begin
            $display("test %0d %s: %s, %0d errors", i_test_num, test_name(i_test_num),
                     (test_fail == 0) ? "ok" : "failed", test_fail);
            test_fail = 0;
        end
        if (i_all_done) $display("checks passed %0d failed %0d, %0d register writes seen",
                                 pass_cnt, fail_cnt, writes);
    end

endmodule

/* dv/hins_tb.sv */
`timescale 1ns/1ps

module hins_tb;

    // rough cycle count of all tests, watchdog adds margin on top
    localparam int TEST_CYCLES = 16 + 64 + 128 + 192 + 8 * hins_pkg::TIMER_DIV + 128
                               + hins_pkg::FREQ_CNT_DEF + 512;
    localparam int WDOG_CYCLES = TEST_CYCLES + 17000;

    logic                        pll_clk_cpu_int = 1'b0;
    logic                        RST_EXT_N;
    logic                        i_pll_locked;
    logic                        i_reg_wr;
    logic [hins_pkg::ADDR_W-1:0] i_reg_waddr;
    logic [hins_pkg::DATA_W-1:0] i_reg_wdata;
    logic [hins_pkg::ADDR_W-1:0] i_reg_raddr;
    logic [hins_pkg::DATA_W-1:0] o_reg_rdata;
    logic                        o_sync;
    logic [hins_pkg::DAC_W-1:0]  o_dac_data;
    logic                        o_dac_rst;

    logic [3:0]  chk_req;          // one-hot check request
    logic [31:0] exp_val;
    logic [31:0] tol;
    logic        sync_mon;
    logic [31:0] sync_period;
    logic        dac_mon;
    logic [15:0] dac_hi;
    logic [15:0] dac_lo;
    logic [31:0] dac_half;
    logic        test_end;
    int          test_num;
    logic        all_done;
    int          fail_cnt;

    integer      seed = 8;
    logic [31:0] shadow [0:15];    // expected register contents
    logic [31:0] rnd;
    logic [31:0] amp_h_val;
    logic [31:0] amp_l_val;

    always #50 pll_clk_cpu_int = ~pll_clk_cpu_int;   // 100 ns period

    hins_top dut0 (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_pll_locked    (i_pll_locked),
        .i_reg_wr        (i_reg_wr),
        .i_reg_waddr     (i_reg_waddr),
        .i_reg_wdata     (i_reg_wdata),
        .i_reg_raddr     (i_reg_raddr),
        .o_reg_rdata     (o_reg_rdata),
        .o_sync          (o_sync),
        .o_dac_data      (o_dac_data),
        .o_dac_rst       (o_dac_rst)
    );

    hins_checker u_chk (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_reg_wr        (i_reg_wr),
        .i_reg_raddr     (i_reg_raddr),
        .i_reg_rdata     (o_reg_rdata),
        .i_sync          (o_sync),
        .i_dac_data      (o_dac_data),
        .i_dac_rst       (o_dac_rst),
        .i_chk_req       (chk_req),
        .i_exp           (exp_val),
        .i_tol           (tol),
        .i_sync_mon      (sync_mon),
        .i_sync_period   (sync_period),
        .i_dac_mon       (dac_mon),
        .i_dac_hi        (dac_hi),
        .i_dac_lo        (dac_lo),
        .i_dac_half      (dac_half),
        .i_test_end      (test_end),
        .i_test_num      (test_num),
        .i_all_done      (all_done),
        .o_fail_cnt      (fail_cnt)
    );

    // midscale plus amp_h in the high half, minus amp_l in the low half, 16-bit wrap
    function automatic logic [15:0] expected_dac(input hins_pkg::mod_state_e st,
                                                 input logic [31:0] amp_h,
                                                 input logic [31:0] amp_l);
        logic [31:0] mid;
        logic [31:0] sum;
        mid = {16'd0, hins_pkg::DAC_MID};
        if (st == hins_pkg::MOD_HIGH) sum = mid + amp_h;
        else sum = mid - amp_l;
        return sum[15:0];
    endfunction

    task automatic load_defaults();
        for (int a = 0; a < 16; a++) shadow[4'(a)] = '0;
        shadow[hins_pkg::REG_FREQ_CNT]   = hins_pkg::FREQ_CNT_DEF;
        shadow[hins_pkg::REG_AMP_H]      = hins_pkg::AMP_H_DEF;
        shadow[hins_pkg::REG_AMP_L]      = hins_pkg::AMP_L_DEF;
        shadow[hins_pkg::REG_SYNC_COUNT] = hins_pkg::SYNC_CNT_DEF;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge pll_clk_cpu_int);
        i_reg_wr    = 1'b1;
        i_reg_waddr = addr;
        i_reg_wdata = data;
        @(negedge pll_clk_cpu_int);
        i_reg_wr    = 1'b0;
        case (addr)
            hins_pkg::REG_FREQ_CNT, hins_pkg::REG_AMP_H,
            hins_pkg::REG_AMP_L, hins_pkg::REG_SYNC_COUNT: shadow[addr] = data;
            hins_pkg::REG_TIMER_RST, hins_pkg::REG_DAC_RST: shadow[addr] = {31'd0, data[0]};
            default: ;                                  // ro or unmapped
        endcase
    endtask

    task automatic request_check(input logic [3:0] sel, input logic [31:0] exp,
                                 input logic [31:0] tolerance);
        @(negedge pll_clk_cpu_int);
        chk_req = sel;
        exp_val = exp;
        tol     = tolerance;
        @(negedge pll_clk_cpu_int);
        chk_req = 4'b0000;
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] exp,
                              input logic [31:0] tolerance);
        @(negedge pll_clk_cpu_int);
        i_reg_raddr = addr;                             // rdata valid one clock later
        request_check(4'b0001, exp, tolerance);
    endtask

    task automatic end_test(input int num);
        @(negedge pll_clk_cpu_int);
        test_end = 1'b1;
        test_num = num;
        @(negedge pll_clk_cpu_int);
        test_end = 1'b0;
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        RST_EXT_N    = 1'b0;
        i_pll_locked = 1'b1;
        i_reg_wr     = 1'b0;
        i_reg_waddr  = '0;
        i_reg_wdata  = '0;
        i_reg_raddr  = '0;
        chk_req      = 4'b0000;
        exp_val      = '0;
        tol          = '0;
        sync_mon     = 1'b0;
        sync_period  = '0;
        dac_mon      = 1'b0;
        dac_hi       = '0;
        dac_lo       = '0;
        dac_half     = '0;
        test_end     = 1'b0;
        test_num     = 0;
        all_done     = 1'b0;
        load_defaults();
        repeat (8) @(negedge pll_clk_cpu_int);
        RST_EXT_N = 1'b1;
        repeat (4) @(negedge pll_clk_cpu_int);    // lock already high

        request_check(4'b0010, 0, 0);
        request_check(4'b0100, 0, 0);
        for (int a = 0; a < 6; a++) read_check(4'(a), shadow[4'(a)], 0);
        read_check(4'd7, 0, 0);
        read_check(4'd15, 0, 0);
        end_test(1);

        for (int a = 0; a < 6; a++) begin
            rnd = $random(seed);
            write_reg(4'(a), rnd);
        end
        for (int a = 0; a < 6; a++) read_check(4'(a), shadow[4'(a)], 0);
        write_reg(hins_pkg::REG_TIMER, $random(seed));
        write_reg(4'd9, $random(seed));
        for (int a = 0; a < 6; a++) read_check(4'(a), shadow[4'(a)], 0);
        read_check(4'd9, 0, 0);
        write_reg(hins_pkg::REG_DAC_RST, 1);
        request_check(4'b0100, 1, 0);
        write_reg(hins_pkg::REG_DAC_RST, 0);
        request_check(4'b0100, 0, 0);
        end_test(2);

        write_reg(hins_pkg::REG_SYNC_COUNT, 7);
        sync_period = 7;
        repeat (3) @(negedge pll_clk_cpu_int);
        sync_mon = 1'b1;
        repeat (70) @(negedge pll_clk_cpu_int);
        sync_mon = 1'b0;
        write_reg(hins_pkg::REG_SYNC_COUNT, 0);
        sync_period = 0;
        repeat (3) @(negedge pll_clk_cpu_int);
        sync_mon = 1'b1;
        repeat (50) @(negedge pll_clk_cpu_int);
        sync_mon = 1'b0;
        end_test(3);

        write_reg(hins_pkg::REG_TIMER_RST, 1);
        read_check(hins_pkg::REG_TIMER, 0, 0);
        repeat (2 * hins_pkg::TIMER_DIV) @(negedge pll_clk_cpu_int);
        read_check(hins_pkg::REG_TIMER, 0, 0);
        write_reg(hins_pkg::REG_TIMER_RST, 0);
        repeat (5 * hins_pkg::TIMER_DIV) @(negedge pll_clk_cpu_int);
        read_check(hins_pkg::REG_TIMER, 5, 1);    // one tick slack
        end_test(4);

        // lock loss first, so the waveform test starts from a known 1000-cycle half
        write_reg(hins_pkg::REG_SYNC_COUNT, 7);
        write_reg(hins_pkg::REG_DAC_RST, 1);
        @(negedge pll_clk_cpu_int);
        i_pll_locked = 1'b0;
        repeat (4) @(negedge pll_clk_cpu_int);
        i_pll_locked = 1'b1;
        load_defaults();
        repeat (3) @(negedge pll_clk_cpu_int);
        sync_mon = 1'b1;                          // period 0, no pulse allowed
        request_check(4'b0100, 0, 0);
        request_check(4'b1000, {16'd0, expected_dac(hins_pkg::MOD_HIGH,
                      hins_pkg::AMP_H_DEF, hins_pkg::AMP_L_DEF)}, 0);
        for (int a = 0; a < 6; a++) read_check(4'(a), shadow[4'(a)], 0);
        sync_mon = 1'b0;
        end_test(6);

        rnd = $random(seed);
        amp_h_val = {18'd0, rnd[13:0]} + 32'd1;   // nonzero, keeps codes distinct
        rnd = $random(seed);
        amp_l_val = {18'd0, rnd[13:0]} + 32'd1;
        write_reg(hins_pkg::REG_FREQ_CNT, 20);
        write_reg(hins_pkg::REG_AMP_H, amp_h_val);
        write_reg(hins_pkg::REG_AMP_L, amp_l_val);
        dac_hi   = expected_dac(hins_pkg::MOD_HIGH, amp_h_val, amp_l_val);
        dac_lo   = expected_dac(hins_pkg::MOD_LOW, amp_h_val, amp_l_val);
        dac_half = 20;
        repeat (hins_pkg::FREQ_CNT_DEF + 40) @(negedge pll_clk_cpu_int);  // old half ends
        dac_mon = 1'b1;
        repeat (10 * 20) @(negedge pll_clk_cpu_int);
        dac_mon = 1'b0;
        end_test(5);

        @(negedge pll_clk_cpu_int);
        all_done = 1'b1;
        @(negedge pll_clk_cpu_int);
        all_done = 1'b0;
        @(negedge pll_clk_cpu_int);
        if (fail_cnt == 0) $display("Result: PASSED");
        else $display("Result: FAILED");
        $finish;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge pll_clk_cpu_int);
        $display("watchdog expired, tests did not finish within %0d cycles", WDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* hins_fog_support.f */
design/hins_pkg.sv
design/hins_rst_sync.sv
design/hins_reg_bank.sv
design/hins_sync_gen.sv
design/hins_timer.sv
design/hins_mod_gen.sv
design/hins_top.sv
dv/hins_checker.sv
dv/hins_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and grade the run from its log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module hins_tb \
    -f hins_fog_support.f \
    --Mdir obj_dir -o hins_sim

./obj_dir/hins_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"
